// ==== Makefile ====
# Verilator build and run for the ID stage instruction buffer

SIM      := verilator
TOP      := id_stage_buffer_tb
FILELIST := id_stage_buffer.f
FLAGS    := --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
PASS_MSG := All checks passed

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up on a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/id_stage_buffer_tb.sv ====
`timescale 1ns/1ps

module id_stage_buffer_tb;

    import id_buffer_pkg::*;

    // How a table row produces its levels
    localparam logic [1:0] mode_plain  = 2'd0;
    localparam logic [1:0] mode_direct = 2'd1;
    localparam logic [1:0] mode_random = 2'd2;

    localparam int num_steps    = 27;
    localparam int reset_cycles = 4;

    // One row of the stimulus table
    typedef struct packed {
        logic       stall;
        logic       inst_valid;
        logic       fetch_hold;
        logic       pc_override;
        logic [1:0] mode;
        logic [7:0] reps;
        logic [3:0] test;
    } step_t;

    logic          clk;
    logic          reset;
    logic          stall;
    logic          inst_valid;
    logic          fetch_hold;
    logic          pc_override;
    fetch_packet_t fetch_packet;
    logic          id_valid;
    logic          if_buffer_stall;
    fetch_packet_t id_packet;

    step_t         steps [num_steps];
    fetch_packet_t expected_q [$];

    logic [31:0] lcg_state;
    logic        packet_taken;
    logic        saw_backpressure;
    int          cycle_count;
    int          cycle_limit;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;

    id_stage_buffer DUT (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .pc_override     (pc_override),
        .inst_valid      (inst_valid),
        .fetch_hold      (fetch_hold),
        .fetch_packet    (fetch_packet),
        .if_buffer_stall (if_buffer_stall),
        .id_valid        (id_valid),
        .id_packet       (id_packet)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus table never finished", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string test_title(input logic [3:0] test);
        case (test)
            4'd1: return "pass-through";
            4'd2: return "stall and drain";
            4'd3: return "back-pressure";
            4'd4: return "redirect";
            4'd5: return "mixed random traffic";
            4'd6: return "reset state";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_problem(input string what);
        $display("Failure at %0t: %s", $time, what);
        test_errors++;
    endtask

    task automatic compare_level(input string name, input logic expected, input logic actual);
        buffer_state_t fsm_state;
        test_checks++;
        if (actual !== expected) begin
            fsm_state = DUT.u_fsm.state;
            $display("Error at %0t: %s expected %0b got %0b in %s",
                     $time, name, expected, actual, fsm_state.name());
            test_errors++;
        end
    endtask

    task automatic match_packet(input fetch_packet_t expected, input fetch_packet_t actual);
        buffer_state_t fsm_state;
        test_checks++;
        if (actual !== expected) begin
            fsm_state = DUT.u_fsm.state;
            $display("Error at %0t: id_packet expected pc %h inst %h got pc %h inst %h in %s",
                     $time, expected.pc, expected.inst, actual.pc, actual.inst,
                     fsm_state.name());
            test_errors++;
        end
    endtask

    task automatic load_steps();
        // Idle after reset with nothing offered
        steps[0]  = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd4,   4'd6};
        // Straight through with an occasional hold
        steps[1]  = '{1'b0, 1'b1, 1'b0, 1'b0, mode_direct, 8'd12,  4'd1};
        steps[2]  = '{1'b0, 1'b1, 1'b1, 1'b0, mode_direct, 8'd2,   4'd1};
        steps[3]  = '{1'b0, 1'b1, 1'b0, 1'b0, mode_direct, 8'd6,   4'd1};
        steps[4]  = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd2,   4'd1};
        // Park three, drain under traffic, then direct again
        steps[5]  = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd2,   4'd2};
        steps[6]  = '{1'b1, 1'b1, 1'b0, 1'b0, mode_plain,  8'd3,   4'd2};
        steps[7]  = '{1'b1, 1'b0, 1'b0, 1'b0, mode_plain,  8'd2,   4'd2};
        steps[8]  = '{1'b0, 1'b1, 1'b0, 1'b0, mode_plain,  8'd6,   4'd2};
        steps[9]  = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd8,   4'd2};
        steps[10] = '{1'b0, 1'b1, 1'b0, 1'b0, mode_direct, 8'd4,   4'd2};
        steps[11] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd2,   4'd2};
        // Long stall until the FIFO fills
        steps[12] = '{1'b1, 1'b1, 1'b0, 1'b0, mode_plain,  8'd10,  4'd3};
        steps[13] = '{1'b0, 1'b1, 1'b0, 1'b0, mode_plain,  8'd6,   4'd3};
        steps[14] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd8,   4'd3};
        // Redirect while draining
        steps[15] = '{1'b1, 1'b1, 1'b0, 1'b0, mode_plain,  8'd3,   4'd4};
        steps[16] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd1,   4'd4};
        steps[17] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd1,   4'd4};
        steps[18] = '{1'b0, 1'b1, 1'b0, 1'b1, mode_plain,  8'd1,   4'd4};
        steps[19] = '{1'b0, 1'b1, 1'b0, 1'b0, mode_direct, 8'd4,   4'd4};
        steps[20] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd4,   4'd4};
        // Redirect while parking
        steps[21] = '{1'b1, 1'b1, 1'b0, 1'b0, mode_plain,  8'd2,   4'd4};
        steps[22] = '{1'b1, 1'b1, 1'b0, 1'b1, mode_plain,  8'd1,   4'd4};
        steps[23] = '{1'b1, 1'b1, 1'b0, 1'b0, mode_plain,  8'd2,   4'd4};
        steps[24] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd8,   4'd4};
        // Random levels, then a quiet tail so everything drains
        steps[25] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_random, 8'd200, 4'd5};
        steps[26] = '{1'b0, 1'b0, 1'b0, 1'b0, mode_plain,  8'd8,   4'd5};
    endtask

    task automatic drive_step(input step_t step);
        logic [31:0] r;
        // Next packet only once the previous one was taken
        if (packet_taken) begin
            lcg_state         = lcg_step(lcg_state);
            fetch_packet.pc   = fetch_packet.pc + 32'd4;
            fetch_packet.inst = lcg_state;
            packet_taken      = 1'b0;
        end
        if (step.mode == mode_random) begin
            lcg_state  = lcg_step(lcg_state);
            r          = lcg_state;
            stall      = (r[31:29] < 3'd3);
            fetch_hold = (r[27:25] == 3'd0);
            inst_valid = (r[23:22] != 2'd0);
        end else begin
            stall      = step.stall;
            inst_valid = step.inst_valid;
            fetch_hold = step.fetch_hold;
        end
        pc_override = step.pc_override;
    endtask

    task automatic score_cycle(input step_t step);
        logic accepted;
        logic consumed;
        accepted = inst_valid && !fetch_hold && !if_buffer_stall && !pc_override;
        consumed = id_valid && !stall;

        if (pc_override) begin
            compare_level("id_valid", 1'b0, id_valid);
        end
        // Outstanding packets equal FIFO occupancy
        if (expected_q.size() > 0 || !stall) begin
            compare_level("if_buffer_stall", expected_q.size() == buffer_depth, if_buffer_stall);
        end
        if (if_buffer_stall) begin
            saw_backpressure = 1'b1;
        end
        if (step.test == 4'd6) begin
            compare_level("id_valid", 1'b0, id_valid);
            compare_level("if_buffer_stall", 1'b0, if_buffer_stall);
        end
        if (step.mode == mode_direct && accepted) begin
            compare_level("id_valid", 1'b1, id_valid);
        end

        if (pc_override) begin
            expected_q.delete();
        end else if (accepted) begin
            expected_q.push_back(fetch_packet);
        end

        if (consumed) begin
            if (expected_q.size() == 0) begin
                test_checks++;
                report_problem("decode consumed a packet that fetch never handed over");
            end else begin
                match_packet(expected_q[0], id_packet);
                void'(expected_q.pop_front());
            end
        end
        packet_taken = accepted;
    endtask

    task automatic finish_test(input logic [3:0] test);
        test_checks++;
        if (expected_q.size() != 0) begin
            report_problem($sformatf("%0d packets never reached decode", expected_q.size()));
        end
        if (test == 4'd3) begin
            test_checks++;
            if (!saw_backpressure) begin
                report_problem("if_buffer_stall never rose with the FIFO full");
            end
        end
        $display("Test %0d %s: %0d checks, %0d errors",
                 test, test_title(test), test_checks, test_errors);
        total_checks     = total_checks + test_checks;
        total_errors     = total_errors + test_errors;
        test_checks      = 0;
        test_errors      = 0;
        saw_backpressure = 1'b0;
    endtask

    initial begin
        int total_cycles;
        reset            = 1'b1;
        stall            = 1'b0;
        inst_valid       = 1'b0;
        fetch_hold       = 1'b0;
        pc_override      = 1'b0;
        lcg_state        = 32'd79;
        lcg_state        = lcg_step(lcg_state);
        fetch_packet.pc  = 32'h0000_1000;
        fetch_packet.inst = lcg_state;
        packet_taken     = 1'b0;
        saw_backpressure = 1'b0;
        test_checks      = 0;
        test_errors      = 0;
        total_checks     = 0;
        total_errors     = 0;

        load_steps();
        total_cycles = reset_cycles;
        for (int s = 0; s < num_steps; s++) begin
            total_cycles = total_cycles + int'(steps[s].reps);
        end
        cycle_limit = 2 * total_cycles + 100;

        // Outputs stay quiet while reset is held
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            #1;
            compare_level("if_buffer_stall", 1'b0, if_buffer_stall);
            compare_level("id_valid", 1'b0, id_valid);
        end
        @(negedge clk);
        reset = 1'b0;

        for (int s = 0; s < num_steps; s++) begin
            for (int k = 0; k < int'(steps[s].reps); k++) begin
                @(negedge clk);
                drive_step(steps[s]);
                #1;
                score_cycle(steps[s]);
            end
            if (s == num_steps - 1 || steps[s + 1].test != steps[s].test) begin
                finish_test(steps[s].test);
            end
        end

        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== id_stage_buffer.f ====
source/id_buffer_pkg.sv
source/id_buffer_fsm.sv
source/inst_fifo.sv
source/id_issue_select.sv
source/id_stage_buffer.sv
dv/id_stage_buffer_tb.sv

// ==== source/id_buffer_fsm.sv ====
`timescale 1ns/1ps

module id_buffer_fsm (
    input  logic clk,
    input  logic reset,

    // Pipeline status
    input  logic stall,
    input  logic inst_valid,
    input  logic fetch_hold,
    input  logic pc_override,

    // FIFO status
    input  logic buffer_is_empty,
    input  logic buffer_is_full,
    input  logic buffer_last,

    // FIFO control
    output logic buffer_write_en,
    output logic buffer_read_en,
    output logic buffer_reset,

    // Issue and fetch control
    output logic buffer_sel,
    output logic if_buffer_stall,
    output logic buffer_active
);

    import id_buffer_pkg::*;

    buffer_state_t state;
    buffer_state_t next_state;

    logic accept;
    logic drain_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= buffer_idle;
        end else begin
            state <= next_state;
        end
    end

    // Back-pressure toward fetch
    // The clear cycle cannot park a packet, so fetch waits if decode is stalled
    always_comb begin
        if (state == id_buffer_pkg::buffer_reset) begin
            if_buffer_stall = stall;
        end else begin
            if_buffer_stall = buffer_is_full;
        end
    end

    // Fetch packet taken this cycle
    assign accept = inst_valid && !fetch_hold && !if_buffer_stall && !pc_override;

    // FIFO strobes and issue select
    always_comb begin
        buffer_write_en = 1'b0;
        buffer_read_en  = 1'b0;
        buffer_sel      = 1'b0;
        buffer_active   = 1'b0;

        case (state)
            buffer_idle: begin
                // Stall just arrived, park the packet at this edge
                buffer_write_en = stall && accept;
            end

            buffer_write: begin
                buffer_write_en = accept;
                buffer_active   = 1'b1;
            end

            buffer_enable: begin
                // New packets queue up behind the head
                buffer_write_en = accept;
                buffer_read_en  = !stall && !buffer_is_empty && !pc_override;
                buffer_sel      = 1'b1;
                buffer_active   = 1'b1;
            end

            default: begin
                // Clear cycle, fetch goes straight to decode
            end
        endcase
    end

    // Clear on the dedicated state, or right away on a redirect
    assign buffer_reset = (state == id_buffer_pkg::buffer_reset) || pc_override;

    // FIFO is empty after this edge
    assign drain_done = !buffer_write_en
                     && (buffer_is_empty || (buffer_last && buffer_read_en));

    always_comb begin
        next_state = state;

        case (state)
            buffer_idle: begin
                if (stall) begin
                    next_state = buffer_write;
                end
            end

            buffer_write: begin
                if (pc_override) begin
                    // FIFO is cleared this edge; nothing left to drain
                    next_state = stall ? buffer_write : buffer_idle;
                end else if (!stall) begin
                    next_state = buffer_enable;
                end
            end

            buffer_enable: begin
                if (pc_override || drain_done) begin
                    next_state = id_buffer_pkg::buffer_reset;
                end
            end

            id_buffer_pkg::buffer_reset: begin
                if (stall) begin
                    next_state = buffer_write;
                end else begin
                    next_state = buffer_idle;
                end
            end

            default: begin
                next_state = buffer_idle;
            end
        endcase
    end

endmodule

// ==== source/id_buffer_pkg.sv ====
package id_buffer_pkg;

    // Datapath widths
    localparam int pc_width   = 32;
    localparam int inst_width = 32;

    // Instruction buffer geometry
    localparam int buffer_depth     = 4;
    localparam int buffer_ptr_width = 2;

    // Instruction address
    typedef logic [pc_width-1:0] pc_t;

    // Raw instruction word
    typedef logic [inst_width-1:0] inst_t;

    // FIFO read/write pointer
    typedef logic [buffer_ptr_width-1:0] buffer_ptr_t;

    // Occupancy, one bit wider than a pointer so a full FIFO can be told apart from empty
    typedef logic [buffer_ptr_width:0] buffer_count_t;

    // One fetched instruction with its address
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_packet_t;

    // Buffer control states
    // idle    direct fetch to decode
    // write   parking packets while decode is stalled
    // enable  decode drains the FIFO head
    // reset   one cycle clear before going back to idle
    typedef enum logic [1:0] {
        buffer_idle   = 2'b00,
        buffer_reset  = 2'b01,
        buffer_write  = 2'b10,
        buffer_enable = 2'b11
    } buffer_state_t;

endpackage

// ==== source/id_issue_select.sv ====
`timescale 1ns/1ps

module id_issue_select (
    // Source selection and status
    input  logic                         buffer_sel,
    input  logic                         direct_valid,
    input  logic                         buffer_empty,
    input  logic                         pc_override,

    // Candidate packets
    input  id_buffer_pkg::fetch_packet_t direct_packet,
    input  id_buffer_pkg::fetch_packet_t head_packet,

    // Toward decode
    output logic                         id_valid,
    output id_buffer_pkg::fetch_packet_t id_packet
);

    logic source_valid;

    // FIFO head while draining, otherwise straight from fetch
    always_comb begin
        if (buffer_sel) begin
            id_packet    = head_packet;
            source_valid = !buffer_empty;
        end else begin
            id_packet    = direct_packet;
            source_valid = direct_valid;
        end
    end

    // Redirect squashes whatever is on offer this cycle
    assign id_valid = source_valid && !pc_override;

endmodule

// ==== source/id_stage_buffer.sv ====
`timescale 1ns/1ps

module id_stage_buffer (
    input  logic                         clk,
    input  logic                         reset,

    // Decode and pipeline control
    input  logic                         stall,
    input  logic                         pc_override,

    // Fetch side
    input  logic                         inst_valid,
    input  logic                         fetch_hold,
    input  id_buffer_pkg::fetch_packet_t fetch_packet,
    output logic                         if_buffer_stall,

    // Decode side
    output logic                         id_valid,
    output id_buffer_pkg::fetch_packet_t id_packet
);

    import id_buffer_pkg::*;

    logic buffer_write_en;
    logic buffer_read_en;
    logic buffer_reset;
    logic buffer_sel;
    logic buffer_active;

    logic buffer_is_empty;
    logic buffer_is_full;
    logic buffer_last;

    logic          direct_valid;
    fetch_packet_t head_packet;

    // Direct path is live only when nothing is being parked or drained
    assign direct_valid = inst_valid && !fetch_hold && !buffer_active;

    id_buffer_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .inst_valid      (inst_valid),
        .fetch_hold      (fetch_hold),
        .pc_override     (pc_override),
        .buffer_is_empty (buffer_is_empty),
        .buffer_is_full  (buffer_is_full),
        .buffer_last     (buffer_last),
        .buffer_write_en (buffer_write_en),
        .buffer_read_en  (buffer_read_en),
        .buffer_reset    (buffer_reset),
        .buffer_sel      (buffer_sel),
        .if_buffer_stall (if_buffer_stall),
        .buffer_active   (buffer_active)
    );

    inst_fifo u_fifo (
        .clk          (clk),
        .reset        (reset),
        .write_en     (buffer_write_en),
        .read_en      (buffer_read_en),
        .clear        (buffer_reset),
        .write_packet (fetch_packet),
        .head_packet  (head_packet),
        .empty        (buffer_is_empty),
        .full         (buffer_is_full),
        .last         (buffer_last)
    );

    id_issue_select u_select (
        .buffer_sel    (buffer_sel),
        .direct_valid  (direct_valid),
        .buffer_empty  (buffer_is_empty),
        .pc_override   (pc_override),
        .direct_packet (fetch_packet),
        .head_packet   (head_packet),
        .id_valid      (id_valid),
        .id_packet     (id_packet)
    );

endmodule

// ==== source/inst_fifo.sv ====
`timescale 1ns/1ps

module inst_fifo (
    input  logic                         clk,
    input  logic                         reset,

    // Control
    input  logic                         write_en,
    input  logic                         read_en,
    input  logic                         clear,

    // Data
    input  id_buffer_pkg::fetch_packet_t write_packet,
    output id_buffer_pkg::fetch_packet_t head_packet,

    // Status
    output logic                         empty,
    output logic                         full,
    output logic                         last
);

    import id_buffer_pkg::*;

    fetch_packet_t mem [buffer_depth];

    buffer_ptr_t   write_ptr;
    buffer_ptr_t   read_ptr;
    buffer_count_t count;

    logic do_write;
    logic do_read;

    // Overflow and underflow protection
    assign do_write = write_en && !full;
    assign do_read  = read_en && !empty;

    // Packet storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[write_ptr] <= write_packet;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
        end else if (clear) begin
            write_ptr <= '0;
            read_ptr  <= '0;
        end else begin
            if (do_write) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (do_read) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Idle, or read and write cancel out
                    count <= count;
                end
            endcase
        end
    end

    // Show-ahead head, stale when empty
    assign head_packet = mem[read_ptr];

    assign empty = (count == '0);
    assign full  = (count == buffer_count_t'(buffer_depth));
    assign last  = (count == buffer_count_t'(1));

endmodule
